//--- hdl/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Load/store buffer depth is a power of two so the pointers wrap on their own
`define LSU_SLB_DEPTH 8

// Pointer width into the load/store buffer
`define LSU_SLB_AW 3

// Byte address width of the data RAM
`define LSU_RAM_AW 10

// Number of bytes in the data RAM
`define LSU_RAM_DEPTH (1 << `LSU_RAM_AW)

`endif

//--- hdl/lsuPkg.sv
package lsuPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;

    // 0 is a byte, 1 a half word, 2 a word
    typedef logic [1:0] lenT;

    // Reorder tag that travels with every request
    typedef logic [3:0] nickT;

    // Bit 1 means idle and accepting, bit 0 means busy with a store
    typedef logic [1:0] mcWaitT;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_ACCESS,
        MC_FINISH
    } mcStateT;

endpackage

//--- hdl/loadStoreBuffer.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module loadStoreBuffer (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          reqEn,
    input  logic          reqLs,
    input  lsuPkg::addrT  reqAddr,
    input  lsuPkg::dataT  reqData,
    input  lsuPkg::lenT   reqLen,
    input  lsuPkg::nickT  reqNick,
    output logic          slbFull,
    input  logic          slbEnOut,
    output logic          issueEn,
    output logic          issueLs,
    output lsuPkg::addrT  issueAddr,
    output lsuPkg::dataT  issueData,
    output lsuPkg::lenT   issueLen,
    output lsuPkg::nickT  issueNick,
    input  logic          slbDone,
    input  lsuPkg::dataT  slbData,
    input  lsuPkg::nickT  slbNick,
    output logic          respDone,
    output lsuPkg::dataT  respData,
    output lsuPkg::nickT  respNick
);
    import lsuPkg::*;

    localparam int depth = `LSU_SLB_DEPTH;

    logic entryLs   [depth];
    addrT entryAddr [depth];
    dataT entryData [depth];
    lenT  entryLen  [depth];
    nickT entryNick [depth];

    logic [`LSU_SLB_AW-1:0] headPtr;
    logic [`LSU_SLB_AW-1:0] tailPtr;
    logic [`LSU_SLB_AW:0]   count;
    logic                   push;
    logic                   empty;

    assign empty   = (count == '0);
    assign slbFull = (count == depth[`LSU_SLB_AW:0]);

    // Requests queue up even while rdy is low
    assign push = reqEn && !slbFull;

    // The data port drops slbEnOut as soon as it has taken the head entry
    assign issueEn   = slbEnOut && !empty;
    assign issueLs   = entryLs[headPtr];
    assign issueAddr = entryAddr[headPtr];
    assign issueData = entryData[headPtr];
    assign issueLen  = entryLen[headPtr];
    assign issueNick = entryNick[headPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            entryLs[tailPtr]   <= reqLs;
            entryAddr[tailPtr] <= reqAddr;
            entryData[tailPtr] <= reqData;
            entryLen[tailPtr]  <= reqLen;
            entryNick[tailPtr] <= reqNick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (issueEn) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({push, issueEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The data port holds slbDone through a pause, so only an active cycle reports it
    always_ff @(posedge clk) begin
        if (rst) begin
            respDone <= 1'b0;
        end else begin
            respDone <= rdy && slbDone;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && slbDone) begin
            respData <= slbData;
            respNick <= slbNick;
        end
    end

    // The core must watch slbFull before it sends
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        reqEn |-> !slbFull)
        else $error("loadStoreBuffer: request sent while the buffer is full");

    // Pointers and count must agree whenever the head entry leaves
    noIssueWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        issueEn |-> (headPtr != tailPtr) || (count == depth[`LSU_SLB_AW:0]))
        else $error("loadStoreBuffer: issue from an empty buffer");

endmodule

//--- hdl/dataPort.sv
`timescale 1ns/1ps

module dataPort (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  lsuPkg::mcWaitT  mcWait,
    input  logic            mcDone,
    input  lsuPkg::dataT    mcRdData,
    output logic            mcEn,
    output logic            mcLs,
    output lsuPkg::addrT    mcAddr,
    output lsuPkg::dataT    mcData,
    output lsuPkg::lenT     mcLen,
    output logic            slbEnOut,
    input  logic            issueEn,
    input  logic            issueLs,
    input  lsuPkg::addrT    issueAddr,
    input  lsuPkg::dataT    issueData,
    input  lsuPkg::lenT     issueLen,
    input  lsuPkg::nickT    issueNick,
    output logic            slbDone,
    output lsuPkg::dataT    slbData,
    output lsuPkg::nickT    slbNick
);
    import lsuPkg::*;

    nickT nick;     // Tag of the request now in memory
    logic occupied;

    assign slbEnOut = !rst && rdy && !occupied && mcWait[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            mcEn     <= 1'b0;
            slbDone  <= 1'b0;
            occupied <= 1'b0;
        end else if (rdy) begin
            if (mcDone) begin
                slbDone  <= 1'b1;
                slbData  <= mcRdData;
                slbNick  <= nick;
                occupied <= 1'b0;
            end else begin
                slbDone <= 1'b0;
            end

            if (issueEn) begin
                mcEn     <= 1'b1;
                mcLs     <= issueLs;
                mcAddr   <= issueAddr;
                mcData   <= issueData;
                mcLen    <= issueLen;
                nick     <= issueNick;
                occupied <= 1'b1;
            end else begin
                mcEn <= 1'b0;
            end
        end
    end

    // The buffer may only issue while slbEnOut is high
    singleOutstanding: assert property (@(posedge clk) disable iff (rst)
        issueEn |-> !occupied)
        else $error("dataPort: issue while a request is outstanding");

endmodule

//--- hdl/memCtrl.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module memCtrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  logic                    mcEn,
    input  logic                    mcLs,
    input  lsuPkg::addrT            mcAddr,
    input  lsuPkg::dataT            mcData,
    input  lsuPkg::lenT             mcLen,
    output lsuPkg::mcWaitT          mcWait,
    output logic                    mcDone,
    output lsuPkg::dataT            mcRdData,
    output logic                    ramWe,
    output logic [`LSU_RAM_AW-1:0]  ramAddr,
    output byte                     ramWdata,
    input  byte                     ramRdata
);
    import lsuPkg::*;

    mcStateT    state;
    logic       lsReg;
    dataT       dataReg;
    logic [1:0] cnt;        // Byte now on the RAM port
    logic [1:0] nextCnt;
    logic [1:0] lastIdx;
    logic       rdValid;    // RAM output holds a load byte
    logic [1:0] rdLane;
    dataT       rdBuf;
    dataT       rdMerged;

    assign nextCnt = cnt + 2'd1;

    assign mcWait = (state == MC_IDLE) ? 2'b10 : {1'b0, lsReg};

    always_comb begin
        rdMerged = rdBuf;
        if (rdValid) begin
            rdMerged[8*rdLane +: 8] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= MC_IDLE;
            lsReg  <= 1'b0;
            cnt    <= '0;
            ramWe  <= 1'b0;
            mcDone <= 1'b0;
        end else if (rdy) begin
            mcDone <= 1'b0;
            case (state)
                MC_IDLE: begin
                    if (mcEn) begin
                        state    <= MC_ACCESS;
                        lsReg    <= mcLs;
                        dataReg  <= mcData;
                        lastIdx  <= {mcLen[1], |mcLen};     // Bytes minus one
                        cnt      <= '0;
                        ramWe    <= mcLs;
                        ramAddr  <= mcAddr[`LSU_RAM_AW-1:0];
                        ramWdata <= mcData[7:0];
                    end
                end
                MC_ACCESS: begin
                    if (cnt == lastIdx) begin
                        state <= MC_FINISH;
                        ramWe <= 1'b0;
                    end else begin
                        cnt      <= nextCnt;
                        ramAddr  <= ramAddr + 1'b1;
                        ramWdata <= dataReg[8*nextCnt +: 8];
                    end
                end
                MC_FINISH: begin
                    // The last load byte is still on the RAM output here
                    mcDone   <= 1'b1;
                    mcRdData <= rdMerged;
                    state    <= MC_IDLE;
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

    // Read bytes are collected every clock so a pause cannot misplace a lane
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= (state == MC_ACCESS) && !lsReg;
        end
        rdLane <= cnt;
        if (rdy && mcEn && state == MC_IDLE) begin
            rdBuf <= '0;    // Upper lanes of short loads stay zero
        end else begin
            rdBuf <= rdMerged;
        end
    end

    // The data port must wait for idle before it starts an access
    startOnlyInIdle: assert property (@(posedge clk) disable iff (rst)
        mcEn |-> state == MC_IDLE)
        else $error("memCtrl: mcEn while an access is in progress");

endmodule

//--- hdl/dataRam.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dataRam (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`LSU_RAM_AW-1:0]  addr,
    input  byte                     wdata,
    output byte                     rdata
);

    byte mem [0:`LSU_RAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // Old contents on a write cycle
    end

endmodule

//--- hdl/lsuTop.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuTop (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          reqEn,
    input  logic          reqLs,
    input  lsuPkg::addrT  reqAddr,
    input  lsuPkg::dataT  reqData,
    input  lsuPkg::lenT   reqLen,
    input  lsuPkg::nickT  reqNick,
    output logic          slbFull,
    output logic          respDone,
    output lsuPkg::dataT  respData,
    output lsuPkg::nickT  respNick
);
    import lsuPkg::*;

    // Buffer to data port
    logic slbEnOut;
    logic issueEn;
    logic issueLs;
    addrT issueAddr;
    dataT issueData;
    lenT  issueLen;
    nickT issueNick;
    logic slbDone;
    dataT slbData;
    nickT slbNick;

    // Data port to memory controller
    logic   mcEn;
    logic   mcLs;
    addrT   mcAddr;
    dataT   mcData;
    lenT    mcLen;
    mcWaitT mcWait;
    logic   mcDone;
    dataT   mcRdData;

    logic                   ramWe;
    logic [`LSU_RAM_AW-1:0] ramAddr;
    byte                    ramWdata;
    byte                    ramRdata;

    loadStoreBuffer u_loadStoreBuffer (.*);

    dataPort u_dataPort (.*);

    memCtrl u_memCtrl (.*);

    dataRam u_dataRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

//--- testbench/tbLsu.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tbLsu;
    import lsuPkg::*;

    localparam int fullTimeout  = 500;
    localparam int drainTimeout = 2000;
    localparam int randomReqs   = 300;
    localparam logic [9:0] winBase = 10'h140;    // Low address bits of the 64-byte test window

    logic clk;
    logic rst;
    logic rdy;
    logic reqEn;
    logic reqLs;
    addrT reqAddr;
    dataT reqData;
    lenT  reqLen;
    nickT reqNick;
    logic slbFull;
    logic respDone;
    dataT respData;
    nickT respNick;

    logic [7:0]  modelMem [0:`LSU_RAM_DEPTH-1];
    dataT        expData [$];
    nickT        expNick [$];
    logic [31:0] lcgState;
    logic        rdyRandom;
    int          reqCount;
    int          respCount;
    int          errCount;
    int          timeoutCount;

    lsuTop u_lsuTop (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .reqEn    (reqEn),
        .reqLs    (reqLs),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqLen   (reqLen),
        .reqNick  (reqNick),
        .slbFull  (slbFull),
        .respDone (respDone),
        .respData (respData),
        .respNick (respNick)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] randVal();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcgState[31:8]};     // Low LCG bits repeat too quickly
    endfunction

    function automatic int byteCount(input lenT len);
        if (len == 2'd0) begin
            return 1;
        end else if (len == 2'd1) begin
            return 2;
        end
        return 4;
    endfunction

    // A store answers with zero and a load reads zero-extended little-endian bytes
    function automatic dataT applyToModel(input logic ls, input addrT addr, input dataT data,
                                          input lenT len);
        dataT                   result;
        int                     nBytes;
        logic [`LSU_RAM_AW-1:0] idx;
        result = '0;
        nBytes = byteCount(len);
        for (int i = 0; i < nBytes; i++) begin
            idx = addr[`LSU_RAM_AW-1:0] + i;    // Wraps like the RAM address
            if (ls) begin
                modelMem[idx] = data[8*i +: 8];
            end else begin
                result[8*i +: 8] = modelMem[idx];
            end
        end
        return result;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
        if (rdyRandom) begin
            rdy = (randVal() % 8) != 0;
        end
    endtask

    task automatic sendRequest(input logic ls, input addrT addr, input dataT data,
                               input lenT len);
        int cycles;
        cycles = 0;
        while (slbFull && cycles < fullTimeout) begin
            nextCycle();
            cycles++;
        end
        if (slbFull) begin
            $display("Timeout: the buffer stayed full for %0d cycles, request not sent",
                     fullTimeout);
            timeoutCount++;
        end else begin
            reqEn   = 1'b1;
            reqLs   = ls;
            reqAddr = addr;
            reqData = data;
            reqLen  = len;
            reqNick = nickT'(reqCount);     // Running tag shows the response order
            expData.push_back(applyToModel(ls, addr, data, len));
            expNick.push_back(nickT'(reqCount));
            reqCount++;
            nextCycle();
            reqEn = 1'b0;
        end
    endtask

    task automatic waitDrain(input int limit);
        int cycles;
        cycles = 0;
        while (respCount != reqCount && cycles < limit) begin
            nextCycle();
            cycles++;
        end
        if (respCount != reqCount) begin
            $display("Timeout: only %0d of %0d responses arrived", respCount, reqCount);
            timeoutCount++;
        end
    endtask

    task automatic sendRandom();
        logic [31:0] r;
        logic        ls;
        lenT         len;
        int          offset;
        r      = randVal();
        ls     = (r % 5) < 2;
        len    = lenT'(randVal() % 3);
        offset = randVal() % (65 - byteCount(len));     // Access stays inside the window
        r      = randVal();
        sendRequest(ls, {r[21:0], winBase + offset[9:0]}, randVal() ^ (randVal() << 16), len);
    endtask

    // Responses are checked half a cycle after the edge that produced them
    always @(negedge clk) begin : respMonitor
        dataT wantData;
        nickT wantNick;
        if (!rst && respDone) begin
            respCount++;
            assert (expData.size() != 0) else begin
                $display("Response with nick %0d arrived while no request was outstanding",
                         respNick);
                errCount++;
            end
            if (expData.size() != 0) begin
                wantData = expData.pop_front();
                wantNick = expNick.pop_front();
                assert (respNick === wantNick) else begin
                    $display("ERR %0t: response nick %0d, expected %0d",
                             $time, respNick, wantNick);
                    errCount++;
                end
                assert (respData === wantData) else begin
                    $display("ERR %0t: response data %h for nick %0d, expected %h",
                             $time, respData, wantNick, wantData);
                    errCount++;
                end
            end
        end
    end

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        reqEn        = 1'b0;
        reqLs        = 1'b0;
        reqAddr      = '0;
        reqData      = '0;
        reqLen       = '0;
        reqNick      = '0;
        lcgState     = 32'd44;
        rdyRandom    = 1'b0;
        reqCount     = 0;
        respCount    = 0;
        errCount     = 0;
        timeoutCount = 0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) begin
            @(negedge clk);
            assert (respDone === 1'b0 && slbFull === 1'b0) else begin
                $display("ERR %0t: respDone %b slbFull %b after reset, expected both low",
                         $time, respDone, slbFull);
                errCount++;
            end
        end
        nextCycle();

        // Fill the window with words so every later load reads known bytes
        for (int i = 0; i < 16; i++) begin
            sendRequest(1'b1, {22'd0, winBase + 10'(4 * i)}, randVal() ^ (randVal() << 12),
                        2'd2);
        end

        sendRequest(1'b1, {22'd0, winBase + 10'd8}, 32'hA5C3_7E19, 2'd2);
        sendRequest(1'b0, {22'd0, winBase + 10'd8}, '0, 2'd2);
        sendRequest(1'b0, {22'd0, winBase + 10'd8}, '0, 2'd1);
        sendRequest(1'b0, {22'd0, winBase + 10'd8}, '0, 2'd0);
        sendRequest(1'b0, {22'd0, winBase + 10'd11}, '0, 2'd0);
        sendRequest(1'b0, {22'd0, winBase + 10'd9}, '0, 2'd1);
        sendRequest(1'b1, {22'd0, winBase + 10'd9}, 32'hFFFF_FF5A, 2'd0);
        sendRequest(1'b1, {22'd0, winBase + 10'd10}, 32'h0000_C3B2, 2'd1);
        sendRequest(1'b0, {22'd0, winBase + 10'd8}, '0, 2'd2);
        waitDrain(drainTimeout);

        // With rdy low nothing issues, so the buffer fills up
        rdy = 1'b0;
        for (int i = 0; i < `LSU_SLB_DEPTH; i++) begin
            assert (slbFull === 1'b0) else begin
                $display("ERR %0t: slbFull high with %0d requests queued", $time, i);
                errCount++;
            end
            sendRandom();
        end
        repeat (4) begin
            assert (slbFull === 1'b1) else begin
                $display("ERR %0t: slbFull low with %0d requests queued",
                         $time, `LSU_SLB_DEPTH);
                errCount++;
            end
            nextCycle();
        end
        assert (respCount == reqCount - `LSU_SLB_DEPTH) else begin
            $display("ERR %0t: %0d responses while rdy was low", $time,
                     respCount - (reqCount - `LSU_SLB_DEPTH));
            errCount++;
        end
        rdy = 1'b1;
        waitDrain(drainTimeout);

        rdyRandom = 1'b1;
        for (int i = 0; i < randomReqs; i++) begin
            repeat (randVal() % 3) nextCycle();
            sendRandom();
        end
        rdyRandom = 1'b0;
        rdy       = 1'b1;
        waitDrain(drainTimeout);

        assert (respCount == reqCount && expData.size() == 0) else begin
            $display("ERR %0t: %0d requests sent but %0d responses received",
                     $time, reqCount, respCount);
            errCount++;
        end

        $display("Requests %0d, responses %0d, errors %0d, timeouts %0d",
                 reqCount, respCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/lsuPkg.sv
hdl/loadStoreBuffer.sv
hdl/dataPort.sv
hdl/memCtrl.sv
hdl/dataRam.sv
hdl/lsuTop.sv
testbench/tbLsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsuPkg.sv
      - hdl/loadStoreBuffer.sv
      - hdl/dataPort.sv
      - hdl/memCtrl.sv
      - hdl/dataRam.sv
      - hdl/lsuTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tbLsu.sv
